// File: tb.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/exec_pipeline.sv
sim/exec_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module exec_pipeline_tb -f tb.f -o exec_sim \
    && ./obj_dir/exec_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// File: sim/exec_pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module exec_pipeline_tb;

    localparam int NUM_INSTR  = 400;
    localparam int NUM_SLOTS  = NUM_INSTR + 3;
    localparam int CLK_PERIOD = 40;

    logic                clk_i;
    logic                rst_n_i;
    logic                flush_i;
    pipe_pkg::id_ex_t    id_i;
    logic [`XLEN-1:0]    load_data_i;
    pipe_pkg::redirect_t redirect_o;
    pipe_pkg::mem_req_t  mem_o;
    pipe_pkg::wb_t       wb_o;

    integer              seed;
    logic [`XLEN-1:0]    model_pc;
    logic [`REG_AW-1:0]  prev_load_rd;
    logic [`XLEN-1:0]    model_rf [32];
    logic [`XLEN-1:0]    tb_rf [32];

    // Expected responses are indexed by issue slot plus three so that the slots
    // before the first instruction read as bubbles
    logic                exp_taken [NUM_SLOTS+3];
    logic                exp_we [NUM_SLOTS+3];
    logic                exp_read [NUM_SLOTS+3];
    logic                exp_regw [NUM_SLOTS+3];
    logic [`REG_AW-1:0]  exp_rd [NUM_SLOTS+3];
    logic [`XLEN-1:0]    exp_target [NUM_SLOTS+3];
    logic [`XLEN-1:0]    exp_addr [NUM_SLOTS+3];
    logic [`XLEN-1:0]    exp_wdata [NUM_SLOTS+3];
    logic [`XLEN-1:0]    exp_result [NUM_SLOTS+3];

    exec_pipeline uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .id_i        (id_i),
        .load_data_i (load_data_i),
        .redirect_o  (redirect_o),
        .mem_o       (mem_o),
        .wb_o        (wb_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Data memory stand-in where every address bit moves the returned word
    function automatic logic [31:0] load_value(input logic [31:0] addr);
        return {addr[12:0], addr[31:13]} ^ 32'h6D2B_79F5;
    endfunction

    function automatic logic [31:0] alu_ref(input isa_pkg::alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            isa_pkg::ALU_ADD:                    return a + b;
            isa_pkg::ALU_SUB:                    return a - b;
            isa_pkg::ALU_AND:                    return a & b;
            isa_pkg::ALU_OR:                     return a | b;
            isa_pkg::ALU_XOR:                    return a ^ b;
            isa_pkg::ALU_SLL:                    return a << b[4:0];
            isa_pkg::ALU_SRL:                    return a >> b[4:0];
            isa_pkg::ALU_SRA:                    return $signed(a) >>> b[4:0];
            isa_pkg::ALU_SLT, isa_pkg::ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
            isa_pkg::ALU_SLTU, isa_pkg::ALU_LTU: return {31'b0, a < b};
            isa_pkg::ALU_EQ:                     return {31'b0, a == b};
            default:                             return '0;
        endcase
    endfunction

    task automatic build_instr(input logic [31:0] pc, output pipe_pkg::id_ex_t ins);
        logic [31:0] r;
        logic [31:0] imm;
        logic [3:0]  kind;
        r    = $random(seed);
        imm  = $random(seed);
        kind = r[3:0];
        ins  = '0;
        ins.valid     = 1'b1;
        ins.pc        = pc;
        ins.pc_plus_4 = pc + 32'd4;
        // A small register set keeps dependences close together
        ins.rs1     = {2'b0, r[6:4]};
        ins.rs2     = {2'b0, r[9:7]};
        ins.rd      = {2'b0, r[12:10]};
        ins.imm_ext = {{20{imm[11]}}, imm[11:0]};
        ins.alu_src = isa_pkg::ALU_SRC_IMM;
        // The instruction right after a load must not read its destination
        if (prev_load_rd != '0 && ins.rs1 == prev_load_rd) begin
            ins.rs1 = '0;
        end
        if (prev_load_rd != '0 && ins.rs2 == prev_load_rd) begin
            ins.rs2 = '0;
        end
        if (kind < 4'd8) begin
            ins.alu_op    = isa_pkg::alu_op_t'(r[16:13] % 4'd10);
            ins.alu_src   = (kind < 4'd5) ? isa_pkg::ALU_SRC_REG : isa_pkg::ALU_SRC_IMM;
            ins.reg_write = 1'b1;
        end else if (kind < 4'd10) begin
            ins.reg_write  = 1'b1;
            ins.result_src = isa_pkg::RES_MEM;
        end else if (kind < 4'd12) begin
            ins.mem_write = 1'b1;
        end else if (kind < 4'd14) begin
            ins.alu_op      = isa_pkg::alu_op_t'(4'd10 + {2'b0, r[18:17] % 2'd3});
            ins.alu_src     = isa_pkg::ALU_SRC_REG;
            ins.invert_cond = r[19];
            ins.is_branch   = 1'b1;
            ins.imm_ext     = {{20{imm[11]}}, imm[11:1], 1'b0};
        end else begin
            ins.is_jump    = 1'b1;
            ins.reg_write  = 1'b1;
            ins.result_src = isa_pkg::RES_PC4;
            ins.jump_src   = (kind == 4'd15) ? isa_pkg::JUMP_SRC_ALU : isa_pkg::JUMP_SRC_PC;
            ins.imm_ext    = {{20{imm[11]}}, imm[11:1], 1'b0};
        end
    endtask

    task automatic model_step(input int k, input pipe_pkg::id_ex_t ins);
        logic [31:0] b;
        logic [31:0] res;
        b   = model_rf[ins.rs2];
        res = alu_ref(ins.alu_op, model_rf[ins.rs1],
                      (ins.alu_src == isa_pkg::ALU_SRC_IMM) ? ins.imm_ext : b);
        exp_taken[k]  = (ins.is_branch & (res[0] ^ ins.invert_cond)) | ins.is_jump;
        exp_target[k] = (ins.jump_src == isa_pkg::JUMP_SRC_ALU) ? {res[31:1], 1'b0}
                                                                : ins.pc + ins.imm_ext;
        exp_we[k]    = ins.mem_write;
        exp_read[k]  = (ins.result_src == isa_pkg::RES_MEM);
        exp_addr[k]  = res;
        exp_wdata[k] = b;
        exp_regw[k]  = ins.reg_write;
        exp_rd[k]    = ins.rd;
        case (ins.result_src)
            isa_pkg::RES_MEM: exp_result[k] = load_value(res);
            isa_pkg::RES_PC4: exp_result[k] = ins.pc + 32'd4;
            default:          exp_result[k] = res;
        endcase
        if (ins.reg_write && ins.rd != '0) begin
            model_rf[ins.rd] = exp_result[k];
        end
        model_pc = exp_taken[k] ? exp_target[k] : ins.pc + 32'd4;
    endtask

    // Slot n-1 is in execute, n-2 in memory and n-3 in writeback
    task automatic check_outputs(input int k);
        check_value("redirect_o.taken", 32'(exp_taken[k-1]), 32'(redirect_o.taken));
        if (exp_taken[k-1]) begin
            check_value("redirect_o.target", exp_target[k-1], redirect_o.target);
        end
        check_value("mem_o.write_enable", 32'(exp_we[k-2]), 32'(mem_o.write_enable));
        check_value("mem_o.read", 32'(exp_read[k-2]), 32'(mem_o.read));
        if (exp_we[k-2] || exp_read[k-2]) begin
            check_value("mem_o.address", exp_addr[k-2], mem_o.address);
        end
        if (exp_we[k-2]) begin
            check_value("mem_o.write_data", exp_wdata[k-2], mem_o.write_data);
        end
        check_value("wb_o.reg_write", 32'(exp_regw[k-3]), 32'(wb_o.reg_write));
        if (exp_regw[k-3]) begin
            check_value("wb_o.rd", 32'(exp_rd[k-3]), 32'(wb_o.rd));
            check_value("wb_o.result", exp_result[k-3], wb_o.result);
        end
    endtask

    task automatic drive_slot(input int n);
        pipe_pkg::id_ex_t ins;
        logic [31:0]      r;
        logic             squash;
        r = $random(seed);
        if (wb_o.reg_write && wb_o.rd != '0) begin
            tb_rf[wb_o.rd] = wb_o.result;
        end
        load_data_i = load_value(exp_addr[n+1]);
        if (n >= NUM_INSTR) begin
            flush_i = 1'b0;
            id_i    = '0;
        end else begin
            // Wrong-path slot after a taken redirect, or one hit by a flush pulse
            flush_i = (r[4:0] == 5'h1F);
            squash  = exp_taken[n+2] | flush_i;
            build_instr(model_pc, ins);
            ins.rd1 = tb_rf[ins.rs1];
            ins.rd2 = tb_rf[ins.rs2];
            id_i    = ins;
            if (squash) begin
                prev_load_rd = '0;
            end else begin
                model_step(n + 3, ins);
                prev_load_rd = (ins.result_src == isa_pkg::RES_MEM) ? ins.rd : '0;
            end
        end
    endtask

    initial begin
        #((NUM_INSTR + 20) * CLK_PERIOD);
        $display("Timeout: the pipeline run did not complete in time");
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int n;
        seed         = 4149;
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        id_i         = '0;
        load_data_i  = '0;
        model_pc     = `RESET_PC;
        prev_load_rd = '0;
        for (n = 0; n < 32; n++) begin
            model_rf[n] = '0;
            tb_rf[n]    = '0;
        end
        for (n = 0; n < NUM_SLOTS + 3; n++) begin
            exp_taken[n]  = 1'b0;
            exp_we[n]     = 1'b0;
            exp_read[n]   = 1'b0;
            exp_regw[n]   = 1'b0;
            exp_rd[n]     = '0;
            exp_target[n] = '0;
            exp_addr[n]   = '0;
            exp_wdata[n]  = '0;
            exp_result[n] = '0;
        end
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        for (n = 0; n < NUM_SLOTS; n++) begin
            if (n > 0) begin
                @(posedge clk_i);
                #1;
            end
            check_outputs(n + 3);
            drive_slot(n);
        end
        for (n = 1; n < 32; n++) begin
            check_value($sformatf("tb_rf[%0d]", n), model_rf[n], tb_rf[n]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/exec_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module exec_pipeline (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  pipe_pkg::id_ex_t     id_i,
    input  logic [`XLEN-1:0]     load_data_i,
    output pipe_pkg::redirect_t  redirect_o,
    output pipe_pkg::mem_req_t   mem_o,
    output pipe_pkg::wb_t        wb_o
);

    pipe_pkg::ex_mem_t   ex_e;
    pipe_pkg::ex_mem_t   mem_q;
    pipe_pkg::wb_t       wb_q;
    logic [`REG_AW-1:0]  rs1_e;
    logic [`REG_AW-1:0]  rs2_e;
    isa_pkg::fwd_sel_t   fwd_a;
    isa_pkg::fwd_sel_t   fwd_b;
    logic                flush_e;
    logic [`XLEN-1:0]    result_m;

    execute_stage u_execute (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_e),
        .id_i           (id_i),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .alu_result_m_i (mem_q.alu_result),
        .result_w_i     (wb_q.result),
        .rs1_e_o        (rs1_e),
        .rs2_e_o        (rs2_e),
        .ex_o           (ex_e),
        .redirect_o     (redirect_o)
    );

    hazard_unit u_hazard (
        .rs1_e_i       (rs1_e),
        .rs2_e_i       (rs2_e),
        .rd_m_i        (mem_q.rd),
        .rd_w_i        (wb_q.rd),
        .reg_write_m_i (mem_q.reg_write),
        .reg_write_w_i (wb_q.reg_write),
        .taken_i       (redirect_o.taken),
        .flush_i       (flush_i),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b),
        .flush_e_o     (flush_e)
    );

    // Load data returns in the same cycle, so the result is chosen before writeback
    always_comb begin
        case (mem_q.result_src)
            isa_pkg::RES_MEM: result_m = load_data_i;
            isa_pkg::RES_PC4: result_m = mem_q.pc_plus_4;
            default:          result_m = mem_q.alu_result;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            mem_q          <= ex_e;
            wb_q.reg_write <= mem_q.valid & mem_q.reg_write;
            wb_q.rd        <= mem_q.rd;
            wb_q.result    <= result_m;
        end
    end

    always_comb begin
        mem_o.address      = mem_q.alu_result;
        mem_o.write_data   = mem_q.write_data;
        mem_o.write_enable = mem_q.valid & mem_q.mem_write;
        mem_o.read         = mem_q.valid & (mem_q.result_src == isa_pkg::RES_MEM);
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module hazard_unit (
    input  logic [`REG_AW-1:0] rs1_e_i,
    input  logic [`REG_AW-1:0] rs2_e_i,
    input  logic [`REG_AW-1:0] rd_m_i,
    input  logic [`REG_AW-1:0] rd_w_i,
    input  logic               reg_write_m_i,
    input  logic               reg_write_w_i,
    input  logic               taken_i,
    input  logic               flush_i,
    output isa_pkg::fwd_sel_t  fwd_a_o,
    output isa_pkg::fwd_sel_t  fwd_b_o,
    output logic               flush_e_o
);

    // The memory stage holds the younger value, so it is checked first
    function automatic isa_pkg::fwd_sel_t pick_fwd(
        input logic [`REG_AW-1:0] rs,
        input logic [`REG_AW-1:0] rd_m,
        input logic               we_m,
        input logic [`REG_AW-1:0] rd_w,
        input logic               we_w
    );
        isa_pkg::fwd_sel_t sel;
        if (rs == '0) begin
            sel = isa_pkg::FWD_REG;
        end else if (we_m && (rd_m == rs)) begin
            sel = isa_pkg::FWD_MEM;
        end else if (we_w && (rd_w == rs)) begin
            sel = isa_pkg::FWD_WB;
        end else begin
            sel = isa_pkg::FWD_REG;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_fwd(rs1_e_i, rd_m_i, reg_write_m_i, rd_w_i, reg_write_w_i);
    assign fwd_b_o = pick_fwd(rs2_e_i, rd_m_i, reg_write_m_i, rd_w_i, reg_write_w_i);

    // A taken redirect squashes the instruction currently in decode
    assign flush_e_o = taken_i | flush_i;

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  pipe_pkg::id_ex_t     id_i,
    input  isa_pkg::fwd_sel_t    fwd_a_i,
    input  isa_pkg::fwd_sel_t    fwd_b_i,
    input  logic [`XLEN-1:0]     alu_result_m_i,
    input  logic [`XLEN-1:0]     result_w_i,
    output logic [`REG_AW-1:0]   rs1_e_o,
    output logic [`REG_AW-1:0]   rs2_e_o,
    output pipe_pkg::ex_mem_t    ex_o,
    output pipe_pkg::redirect_t  redirect_o
);

    pipe_pkg::id_ex_t   id_e;
    logic [`XLEN-1:0]   src_a;
    logic [`XLEN-1:0]   write_data;
    logic [`XLEN-1:0]   src_b;
    logic [`XLEN-1:0]   alu_result;
    logic               cond;
    logic [`XLEN-1:0]   pc_target;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input isa_pkg::fwd_sel_t sel,
        input logic [`XLEN-1:0]  reg_val,
        input logic [`XLEN-1:0]  wb_val,
        input logic [`XLEN-1:0]  mem_val
    );
        logic [`XLEN-1:0] val;
        case (sel)
            isa_pkg::FWD_WB:  val = wb_val;
            isa_pkg::FWD_MEM: val = mem_val;
            default:          val = reg_val;
        endcase
        return val;
    endfunction

    // A flush loads a bubble, so the squashed instruction has no side effects
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            id_e    <= '0;
            id_e.pc <= `RESET_PC;
        end else begin
            id_e <= id_i;
        end
    end

    assign src_a      = fwd_mux(fwd_a_i, id_e.rd1, result_w_i, alu_result_m_i);
    assign write_data = fwd_mux(fwd_b_i, id_e.rd2, result_w_i, alu_result_m_i);

    always_comb begin
        case (id_e.alu_src)
            isa_pkg::ALU_SRC_IMM: src_b = id_e.imm_ext;
            default:              src_b = write_data;
        endcase
    end

    alu u_alu (
        .src_a_i       (src_a),
        .src_b_i       (src_b),
        .op_i          (id_e.alu_op),
        .invert_cond_i (id_e.invert_cond),
        .result_o      (alu_result),
        .cond_o        (cond)
    );

    // For jalr the ALU has already added rs1 and the immediate
    always_comb begin
        case (id_e.jump_src)
            isa_pkg::JUMP_SRC_ALU: pc_target = {alu_result[`XLEN-1:1], 1'b0};
            default:               pc_target = id_e.pc + id_e.imm_ext;
        endcase
    end

    always_comb begin
        redirect_o.taken  = id_e.valid & ((id_e.is_branch & cond) | id_e.is_jump);
        redirect_o.target = pc_target;
    end

    always_comb begin
        ex_o.valid      = id_e.valid;
        ex_o.alu_result = alu_result;
        ex_o.write_data = write_data;
        ex_o.rd         = id_e.rd;
        ex_o.pc_plus_4  = id_e.pc_plus_4;
        ex_o.reg_write  = id_e.reg_write;
        ex_o.mem_write  = id_e.mem_write;
        ex_o.result_src = id_e.result_src;
    end

    assign rs1_e_o = id_e.rs1;
    assign rs2_e_o = id_e.rs2;

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module alu (
    input  logic [`XLEN-1:0] src_a_i,
    input  logic [`XLEN-1:0] src_b_i,
    input  isa_pkg::alu_op_t op_i,
    input  logic             invert_cond_i,
    output logic [`XLEN-1:0] result_o,
    output logic             cond_o
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       is_cmp;
    logic       cmp_raw;

    assign shamt = src_b_i[4:0];
    assign eq    = (src_a_i == src_b_i);
    assign lt    = ($signed(src_a_i) < $signed(src_b_i));
    assign ltu   = (src_a_i < src_b_i);

    always_comb begin
        result_o = '0;
        is_cmp   = 1'b0;
        cmp_raw  = 1'b0;
        case (op_i)
            isa_pkg::ALU_ADD:  result_o = src_a_i + src_b_i;
            isa_pkg::ALU_SUB:  result_o = src_a_i - src_b_i;
            isa_pkg::ALU_AND:  result_o = src_a_i & src_b_i;
            isa_pkg::ALU_OR:   result_o = src_a_i | src_b_i;
            isa_pkg::ALU_XOR:  result_o = src_a_i ^ src_b_i;
            isa_pkg::ALU_SLL:  result_o = src_a_i << shamt;
            isa_pkg::ALU_SRL:  result_o = src_a_i >> shamt;
            isa_pkg::ALU_SRA:  result_o = $unsigned($signed(src_a_i) >>> shamt);
            isa_pkg::ALU_SLT:  result_o[0] = lt;
            isa_pkg::ALU_SLTU: result_o[0] = ltu;
            // Compares put the raw flag on the result as a set-less-than style value
            isa_pkg::ALU_EQ: begin
                result_o[0] = eq;
                is_cmp      = 1'b1;
                cmp_raw     = eq;
            end
            isa_pkg::ALU_LT: begin
                result_o[0] = lt;
                is_cmp      = 1'b1;
                cmp_raw     = lt;
            end
            isa_pkg::ALU_LTU: begin
                result_o[0] = ltu;
                is_cmp      = 1'b1;
                cmp_raw     = ltu;
            end
            default: result_o = '0;
        endcase
    end

    // Bne, bge and bgeu are the inverted forms of beq, blt and bltu
    assign cond_o = is_cmp & (cmp_raw ^ invert_cond_i);

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

`include "core_settings.svh"

package pipe_pkg;

    // Decode bundle with operands and control registered together into execute
    typedef struct packed {
        logic                      valid;
        logic [`XLEN-1:0]          rd1;
        logic [`XLEN-1:0]          rd2;
        logic [`XLEN-1:0]          pc;
        logic [`REG_AW-1:0]        rs1;
        logic [`REG_AW-1:0]        rs2;
        logic [`REG_AW-1:0]        rd;
        logic [`XLEN-1:0]          imm_ext;
        logic [`XLEN-1:0]          pc_plus_4;
        isa_pkg::alu_op_t          alu_op;
        isa_pkg::alu_src_t         alu_src;
        isa_pkg::jump_src_t        jump_src;
        logic                      invert_cond;
        logic                      is_branch;
        logic                      is_jump;
        logic                      reg_write;
        logic                      mem_write;
        isa_pkg::result_src_t      result_src;
    } id_ex_t;

    typedef struct packed {
        logic                      valid;
        logic [`XLEN-1:0]          alu_result;
        logic [`XLEN-1:0]          write_data;
        logic [`REG_AW-1:0]        rd;
        logic [`XLEN-1:0]          pc_plus_4;
        logic                      reg_write;
        logic                      mem_write;
        isa_pkg::result_src_t      result_src;
    } ex_mem_t;

    typedef struct packed {
        logic [`XLEN-1:0]          address;
        logic [`XLEN-1:0]          write_data;
        logic                      write_enable;
        logic                      read;
    } mem_req_t;

    typedef struct packed {
        logic                      reg_write;
        logic [`REG_AW-1:0]        rd;
        logic [`XLEN-1:0]          result;
    } wb_t;

    typedef struct packed {
        logic                      taken;
        logic [`XLEN-1:0]          target;
    } redirect_t;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        // Branch compares also drive the condition output
        ALU_EQ   = 4'd10,
        ALU_LT   = 4'd11,
        ALU_LTU  = 4'd12
    } alu_op_t;

    typedef enum logic {
        ALU_SRC_REG = 1'b0,
        ALU_SRC_IMM = 1'b1
    } alu_src_t;

    // Jalr takes its target from the ALU, branches and jal from PC plus immediate
    typedef enum logic {
        JUMP_SRC_PC  = 1'b0,
        JUMP_SRC_ALU = 1'b1
    } jump_src_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of the integer data path
`define XLEN 32

// Register file address width for 32 architectural registers
`define REG_AW 5

// PC value held by a bubble after reset
`define RESET_PC 32'h0000_0000

`endif
